/* logic/spi_wr_pkg.sv */
package spi_wr_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int BYTE_W    = 8;                // bits per spi byte
    localparam int BIT_CNT_W = $clog2(BYTE_W);   // bit slot counter width

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [9:0]        div_t;            // sck divider in clk cycles
    typedef logic [15:0]       cnt_t;            // lead / trail / guard delays
    typedef logic [7:0]        bcnt_t;           // bytes per frame

    // smallest divider, i.e. sck at half of CLK_I
    localparam div_t MIN_DIV = 10'd2;

    //////////////////////////////////////////////////////////////////////
    // commands and controller states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        CMD_SINGLE = 1'b0,                       // one frame per cs low
        CMD_STREAM = 1'b1                        // frames chained under one cs low
    } cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_LEAD  = 3'd1,                         // cs low, sck not yet running
        ST_SHIFT = 3'd2,
        ST_TRAIL = 3'd3,                         // sck stopped, cs still low
        ST_GUARD = 3'd4                          // cs high, still busy
    } frame_state_e;

endpackage

/* logic/spi_shift_if.sv */
interface spi_shift_if
    import spi_wr_pkg::*;
#(
    parameter int MAX_BYTES = 4
) ();

    // controller -> shifter
    logic                          load;         // one-cycle strobe
    logic [MAX_BYTES*BYTE_W-1:0]   load_data;    // payload, low bytes valid
    bcnt_t                         load_cnt;     // 1..MAX_BYTES

    // shifter -> controller
    logic                          last_byte;    // final byte on the line
    logic                          frame_done;   // last bit slot ends

    modport ctrl (
        output load,
        output load_data,
        output load_cnt,
        input  last_byte,
        input  frame_done
    );

    modport shifter (
        input  load,
        input  load_data,
        input  load_cnt,
        output last_byte,
        output frame_done
    );

endinterface

/* logic/spi_sck_gen.sv */
module spi_sck_gen
    import spi_wr_pkg::*;
(
    input  logic CLK_I,
    input  logic RST_I,
    input  div_t div_i,
    input  logic run_i,
    output logic sck_o,
    output logic sck_lead_o,
    output logic sck_trail_o
);

    div_t       div_eff;
    logic [8:0] half_m1;
    logic [8:0] cnt_q;
    logic       sck_q;
    logic       en;
    logic       tick;

    //////////////////////////////////////////////////////////////////////
    // divider clamp
    //////////////////////////////////////////////////////////////////////

    assign div_eff = (div_i < MIN_DIV) ? MIN_DIV : {div_i[9:1], 1'b0};   // even, >= 2
    assign half_m1 = div_eff[9:1] - 1'b1;

    // keeps going while sck is high so the last period is whole
    assign en   = run_i | sck_q;
    assign tick = en && (cnt_q >= half_m1);  // >= covers a divider change mid-count

    // strobes come in the cycle before the level moves
    assign sck_lead_o  = tick && !sck_q;
    assign sck_trail_o = tick && sck_q;
    assign sck_o       = sck_q;

    //////////////////////////////////////////////////////////////////////
    // half period counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            cnt_q <= '0;
            sck_q <= 1'b0;
        end else if (!en) begin
            cnt_q <= '0;                     // parked at idle level
        end else if (tick) begin
            cnt_q <= '0;
            sck_q <= ~sck_q;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    a_cnt_range : assert property (@(posedge CLK_I) disable iff (RST_I)
        $stable(div_i) |-> (cnt_q <= half_m1))
        else $error("sck half period counter ran past the divider");

endmodule

/* logic/spi_byte_shifter.sv */
module spi_byte_shifter
    import spi_wr_pkg::*;
#(
    parameter int MAX_BYTES = 4
) (
    input  logic         CLK_I,
    input  logic         RST_I,
    input  logic         pha_i,
    input  logic         sck_lead_i,
    input  logic         sck_trail_i,
    spi_shift_if.shifter shift_if,
    output logic         do_o
);

    logic [MAX_BYTES*BYTE_W-1:0] frame_q;
    bcnt_t                       byte_idx_q;   // byte on the line, counts down to 0
    bcnt_t                       nxt_idx;
    bcnt_t                       load_idx;
    logic [BIT_CNT_W-1:0]        bit_cnt_q;    // trailing edges seen in this byte
    byte_t                       shreg_q;
    byte_t                       cur_byte;
    byte_t                       next_byte;
    byte_t                       shifted;
    logic                        active_q;
    logic                        byte_end;

    assign load_idx  = shift_if.load_cnt - 1'b1;             // highest valid byte
    assign nxt_idx   = (byte_idx_q == '0) ? '0 : byte_idx_q - 1'b1;
    assign cur_byte  = frame_q[BYTE_W*byte_idx_q +: BYTE_W];
    assign next_byte = frame_q[BYTE_W*nxt_idx +: BYTE_W];
    assign shifted   = {shreg_q[BYTE_W-2:0], 1'b0};
    assign byte_end  = sck_trail_i && (bit_cnt_q == '1);

    assign shift_if.last_byte  = active_q && (byte_idx_q == '0);
    assign shift_if.frame_done = active_q && byte_end && (byte_idx_q == '0);
    assign do_o                = shreg_q[BYTE_W-1];          // msb first

    //////////////////////////////////////////////////////////////////////
    // byte and bit counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            active_q   <= 1'b0;
            byte_idx_q <= '0;
            bit_cnt_q  <= '0;
        end else if (shift_if.load) begin
            active_q   <= 1'b1;
            byte_idx_q <= load_idx;
            bit_cnt_q  <= '0;
        end else if (active_q && sck_trail_i) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;                    // wraps per byte
            if (shift_if.frame_done) begin
                active_q <= 1'b0;
            end else if (byte_end) begin
                byte_idx_q <= nxt_idx;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I) begin
        if (shift_if.load) begin
            frame_q <= shift_if.load_data;
            if (!pha_i) begin                  // pha 1 picks the byte up on the first lead
                shreg_q <= shift_if.load_data[BYTE_W*load_idx +: BYTE_W];
            end
        end else if (active_q) begin
            if (sck_trail_i && !pha_i) begin
                shreg_q <= byte_end ? next_byte : shifted;
            end else if (sck_lead_i && pha_i) begin
                shreg_q <= (bit_cnt_q == '0) ? cur_byte : shifted;
            end
        end
    end

    a_load_gap : assert property (@(posedge CLK_I) disable iff (RST_I)
        shift_if.load |-> (!active_q || shift_if.frame_done))
        else $error("frame load while a frame is still shifting");

endmodule

/* logic/spi_frame_ctrl.sv */
module spi_frame_ctrl
    import spi_wr_pkg::*;
#(
    parameter int   MAX_BYTES    = 4,
    parameter cnt_t LEAD_CYCLES  = 16'd4,
    parameter cnt_t TRAIL_CYCLES = 16'd4,
    parameter cnt_t GUARD_CYCLES = 16'd4
) (
    input  logic                        CLK_I,
    input  logic                        RST_I,
    input  cmd_e                        cmd_i,
    input  logic [MAX_BYTES*BYTE_W-1:0] payload_i,
    input  bcnt_t                       byte_cnt_i,
    input  logic                        start_i,
    input  logic                        sck_trail_i,
    spi_shift_if.ctrl                   shift_if,
    output logic                        run_o,
    output logic                        cs_o,
    output logic                        busy_o,
    output logic                        almost_o
);

    frame_state_e                state_q;
    cmd_e                        cmd_q;
    cnt_t                        dly_q;
    logic                        dly_end;
    logic                        start_d;
    logic                        start_edge;
    logic                        busy_q;
    bcnt_t                       in_cnt;
    logic                        q_valid_q;
    logic [MAX_BYTES*BYTE_W-1:0] q_payload_q;
    bcnt_t                       q_cnt_q;
    logic                        q_push;
    logic                        q_take;
    logic                        ending;
    logic                        almost_hit;
    logic                        almost_done_q;

    assign start_edge = start_i && !start_d;
    assign in_cnt     = (byte_cnt_i == '0)       ? bcnt_t'(1) :
                        (byte_cnt_i > MAX_BYTES) ? bcnt_t'(MAX_BYTES) : byte_cnt_i;
    assign dly_end    = (dly_q <= cnt_t'(1));
    assign busy_o     = start_i | busy_q;

    //////////////////////////////////////////////////////////////////////
    // stream queue, one frame deep
    //////////////////////////////////////////////////////////////////////

    assign ending = shift_if.frame_done && !q_valid_q;               // last frame ends
    assign q_take = shift_if.frame_done && q_valid_q;
    assign q_push = start_edge && (cmd_q == CMD_STREAM) &&
                    ((state_q == ST_LEAD) || ((state_q == ST_SHIFT) && !ending));

    // idle loads straight from the inputs, later frames from the queue
    assign shift_if.load      = ((state_q == ST_IDLE) && start_edge) || q_take;
    assign shift_if.load_data = (state_q == ST_IDLE) ? payload_i : q_payload_q;
    assign shift_if.load_cnt  = (state_q == ST_IDLE) ? in_cnt : q_cnt_q;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            start_d   <= 1'b1;                  // start held over reset is no edge
            q_valid_q <= 1'b0;
        end else begin
            start_d <= start_i;
            if (q_push) begin
                q_valid_q <= 1'b1;              // later edge overwrites
            end else if (q_take) begin
                q_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK_I) begin
        if (q_push) begin
            q_payload_q <= payload_i;
            q_cnt_q     <= in_cnt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state_q <= ST_IDLE;
            cmd_q   <= CMD_SINGLE;
            dly_q   <= '0;
            run_o   <= 1'b0;
            cs_o    <= 1'b1;
            busy_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_edge) begin
                        cmd_q   <= cmd_i;
                        cs_o    <= 1'b0;
                        busy_q  <= 1'b1;
                        dly_q   <= LEAD_CYCLES;
                        state_q <= ST_LEAD;
                    end
                end
                ST_LEAD: begin
                    if (dly_end) begin
                        run_o   <= 1'b1;
                        state_q <= ST_SHIFT;
                    end else begin
                        dly_q <= dly_q - 1'b1;
                    end
                end
                ST_SHIFT: begin
                    if (ending) begin
                        run_o   <= 1'b0;        // sck already back at idle level
                        dly_q   <= TRAIL_CYCLES;
                        state_q <= ST_TRAIL;
                    end
                end
                ST_TRAIL: begin
                    if (dly_end) begin
                        cs_o    <= 1'b1;
                        dly_q   <= GUARD_CYCLES;
                        state_q <= ST_GUARD;
                    end else begin
                        dly_q <= dly_q - 1'b1;
                    end
                end
                ST_GUARD: begin
                    if (dly_end) begin
                        busy_q  <= 1'b0;
                        state_q <= ST_IDLE;
                    end else begin
                        dly_q <= dly_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // almost pulse
    //////////////////////////////////////////////////////////////////////

    // first trailing edge inside the last byte of a stream frame
    assign almost_hit = (cmd_q == CMD_STREAM) && (state_q == ST_SHIFT) &&
                        shift_if.last_byte && sck_trail_i && !almost_done_q;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            almost_o      <= 1'b0;
            almost_done_q <= 1'b0;
        end else begin
            almost_o <= almost_hit;
            if (shift_if.load) begin
                almost_done_q <= 1'b0;          // rearm per frame
            end else if (almost_hit) begin
                almost_done_q <= 1'b1;
            end
        end
    end

    a_cs_after_run : assert property (@(posedge CLK_I) disable iff (RST_I)
        $rose(cs_o) |-> (!run_o && !$past(run_o)))
        else $error("cs released while sck still running");

endmodule

/* logic/spi_wr_top.sv */
module spi_wr_top
    import spi_wr_pkg::*;
#(
    parameter int   MAX_BYTES    = 4,
    parameter cnt_t LEAD_CYCLES  = 16'd4,
    parameter cnt_t TRAIL_CYCLES = 16'd4,
    parameter cnt_t GUARD_CYCLES = 16'd4
) (
    input  logic                        CLK_I,
    input  logic                        RST_I,
    input  cmd_e                        cmd_i,
    input  logic [MAX_BYTES*BYTE_W-1:0] payload_i,
    input  bcnt_t                       byte_cnt_i,
    input  logic                        start_i,
    input  div_t                        div_i,
    input  logic                        pol_i,
    input  logic                        pha_i,
    output logic                        busy_o,
    output logic                        almost_o,
    output logic                        spi_cs_o,
    output logic                        spi_sck_o,
    output logic                        spi_do_o
);

    logic run;
    logic sck_lvl;                                  // sck before polarity
    logic sck_lead;
    logic sck_trail;

    spi_shift_if #(.MAX_BYTES(MAX_BYTES)) shift_bus ();

    spi_sck_gen u_sck_gen (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .div_i       (div_i),
        .run_i       (run),
        .sck_o       (sck_lvl),
        .sck_lead_o  (sck_lead),
        .sck_trail_o (sck_trail)
    );

    spi_byte_shifter #(.MAX_BYTES(MAX_BYTES)) u_shifter (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .pha_i       (pha_i),
        .sck_lead_i  (sck_lead),
        .sck_trail_i (sck_trail),
        .shift_if    (shift_bus.shifter),
        .do_o        (spi_do_o)
    );

    spi_frame_ctrl #(
        .MAX_BYTES    (MAX_BYTES),
        .LEAD_CYCLES  (LEAD_CYCLES),
        .TRAIL_CYCLES (TRAIL_CYCLES),
        .GUARD_CYCLES (GUARD_CYCLES)
    ) u_ctrl (
        .CLK_I       (CLK_I),
        .RST_I       (RST_I),
        .cmd_i       (cmd_i),
        .payload_i   (payload_i),
        .byte_cnt_i  (byte_cnt_i),
        .start_i     (start_i),
        .sck_trail_i (sck_trail),
        .shift_if    (shift_bus.ctrl),
        .run_o       (run),
        .cs_o        (spi_cs_o),
        .busy_o      (busy_o),
        .almost_o    (almost_o)
    );

    assign spi_sck_o = sck_lvl ^ pol_i;             // idles at pol_i

endmodule

/* dv/spi_wr_tb.sv */
module spi_wr_tb
    import spi_wr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_BYTES       = 4;
    localparam int PAY_W           = MAX_BYTES * BYTE_W;
    localparam int LEAD            = 3;
    localparam int TRAIL           = 2;
    localparam int GUARD           = 3;
    localparam int NUM_GROUPS      = 40;
    localparam int MAX_FRAMES      = 3;
    localparam int MAX_DIV         = 12;
    localparam int WORST_FRAME     = LEAD + TRAIL + GUARD + MAX_BYTES * BYTE_W * MAX_DIV + 16;
    localparam int WATCHDOG_CYCLES = 2 * NUM_GROUPS * MAX_FRAMES * WORST_FRAME;

    logic             clk;
    logic             rst;
    cmd_e             cmd;
    logic [PAY_W-1:0] payload;
    bcnt_t            byte_cnt;
    logic             start;
    div_t             div;
    logic             pol;
    logic             pha;
    logic             busy;
    logic             almost;
    logic             spi_cs;
    logic             spi_sck;
    logic             spi_do;

    int         seed = 32'h2f28_9524;
    int         half;                        // expected sck half period in cycles
    logic [9:0] exp_q[$];                    // {stream, last byte, data}
    logic [9:0] rx_exp;
    byte_t      rx_byte;
    int         rx_bits;
    int         since_edge;                  // cycles since the last sck edge
    int         since_cs;                    // cycles since cs fell
    int         cs_falls;                    // cs low periods in the current group
    int         almost_cnt;
    int         stream_frames;
    logic       sck_lvl;
    logic       sck_prev;
    logic       cs_prev;
    logic       busy_prev;
    logic       edge_seen;
    logic       almost_seen;

    spi_wr_top #(
        .MAX_BYTES    (MAX_BYTES),
        .LEAD_CYCLES  (cnt_t'(LEAD)),
        .TRAIL_CYCLES (cnt_t'(TRAIL)),
        .GUARD_CYCLES (cnt_t'(GUARD))
    ) uut (
        .CLK_I      (clk),
        .RST_I      (rst),
        .cmd_i      (cmd),
        .payload_i  (payload),
        .byte_cnt_i (byte_cnt),
        .start_i    (start),
        .div_i      (div),
        .pol_i      (pol),
        .pha_i      (pha),
        .busy_o     (busy),
        .almost_o   (almost),
        .spi_cs_o   (spi_cs),
        .spi_sck_o  (spi_sck),
        .spi_do_o   (spi_do)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_fail(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // spi receiver model
    //////////////////////////////////////////////////////////////////////

    task automatic take_bit(input logic b);
        rx_byte = {rx_byte[BYTE_W-2:0], b};  // msb first
        rx_bits++;
        if (rx_bits == BYTE_W) begin
            assert (exp_q.size() > 0)
                else stop_with_fail("receiver got a byte while no byte was expected");
            rx_exp = exp_q.pop_front();
            assert (rx_byte == rx_exp[7:0])
                else stop_with_fail($sformatf("error at %0t: got byte %02h, expected %02h",
                                              $time, rx_byte, rx_exp[7:0]));
            if (rx_exp[9] && rx_exp[8]) begin
                assert (almost_seen)
                    else stop_with_fail($sformatf("error at %0t: stream frame ended %s",
                                                  $time, "without an almost pulse"));
                almost_seen = 1'b0;
            end
            rx_bits = 0;
        end
    endtask

    // outputs are read at the rising edge, before the DUT updates them
    always @(posedge clk) begin
        if (rst) begin
            sck_prev    = 1'b0;
            cs_prev     = 1'b1;
            busy_prev   = 1'b0;
            edge_seen   = 1'b0;
            almost_seen = 1'b0;
            since_edge  = 0;
            since_cs    = 0;
            rx_bits     = 0;
            almost_cnt  = 0;
        end else begin
            sck_lvl = spi_sck ^ pol;
            since_edge++;
            since_cs++;
            if (spi_cs) begin
                assert (spi_sck == pol)
                    else stop_with_fail($sformatf("error at %0t: sck %b with cs high, pol %b",
                                                  $time, spi_sck, pol));
            end
            if (!spi_cs && cs_prev) begin
                since_cs  = 0;
                edge_seen = 1'b0;
                cs_falls++;
            end
            if (spi_cs && !cs_prev) begin
                assert (since_edge >= TRAIL)
                    else stop_with_fail($sformatf("error at %0t: cs rose %0d cycles after sck",
                                                  $time, since_edge));
            end
            if (!spi_cs && (sck_lvl != sck_prev)) begin
                if (edge_seen) begin
                    assert (since_edge == half)
                        else stop_with_fail($sformatf("error at %0t: half period %0d, want %0d",
                                                      $time, since_edge, half));
                end else begin
                    assert (since_cs >= LEAD)
                        else stop_with_fail($sformatf("error at %0t: first sck edge %0d %s",
                                                      $time, since_cs, "cycles after cs"));
                end
                edge_seen  = 1'b1;
                since_edge = 0;
                if (sck_lvl != pha) begin        // lead edge for pha 0, trail for pha 1
                    take_bit(spi_do);
                end
            end
            if (almost) begin
                assert ((exp_q.size() > 0) && exp_q[0][9] && exp_q[0][8] &&
                        !almost_seen && (rx_bits == 1))
                    else stop_with_fail($sformatf("error at %0t: almost pulse out of place",
                                                  $time));
                almost_seen = 1'b1;
                almost_cnt++;
            end
            if (!busy && busy_prev) begin
                assert (since_edge >= TRAIL + GUARD)
                    else stop_with_fail($sformatf("error at %0t: busy fell %0d cycles after sck",
                                                  $time, since_edge));
            end
            sck_prev  = sck_lvl;
            cs_prev   = spi_cs;
            busy_prev = busy;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic rand_frame(output logic [PAY_W-1:0] pay, output bcnt_t cnt);
        pay = PAY_W'($random(seed));
        cnt = bcnt_t'($unsigned($random(seed)) % (MAX_BYTES + 1));   // 0 acts as 1
    endtask

    task automatic push_frame(input logic [PAY_W-1:0] pay, input bcnt_t cnt,
                              input logic stream);
        int n;
        n = (cnt == '0) ? 1 : int'(cnt);
        for (int i = n - 1; i >= 0; i--) begin
            exp_q.push_back({stream, (i == 0), pay[BYTE_W*i +: BYTE_W]});
        end
    endtask

    task automatic pulse_start(input logic [PAY_W-1:0] pay, input bcnt_t cnt,
                               input logic check_cs);
        payload  = pay;
        byte_cnt = cnt;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (check_cs) begin
            assert (!spi_cs)
                else stop_with_fail($sformatf("error at %0t: cs still high after start",
                                              $time));
        end
        @(negedge clk);
    endtask

    task automatic run_group();
        int               r;
        int               dv;
        int               frames;
        logic             stream;
        logic [PAY_W-1:0] pay;
        bcnt_t            cnt;
        r        = $random(seed);
        dv       = 2 + int'($unsigned($random(seed)) % 11);
        stream   = r[2];
        frames   = stream ? 1 + int'(r[5:4]) % MAX_FRAMES : 1;
        pol      = r[0];
        pha      = r[1];
        cmd      = stream ? CMD_STREAM : CMD_SINGLE;
        div      = div_t'(dv);
        half     = (dv - dv % 2) / 2;            // divider rounded down to even
        cs_falls = 0;
        repeat (2) @(negedge clk);
        rand_frame(pay, cnt);
        push_frame(pay, cnt, stream);
        pulse_start(pay, cnt, 1'b1);
        for (int f = 1; f < frames; f++) begin
            while (!almost) begin
                @(negedge clk);
            end
            if (r[6+f]) begin                    // queued frame gets replaced
                rand_frame(pay, cnt);
                pulse_start(pay, cnt, 1'b0);
            end
            rand_frame(pay, cnt);
            push_frame(pay, cnt, stream);
            pulse_start(pay, cnt, 1'b0);
        end
        if (!stream) begin                       // dropped while busy
            rand_frame(pay, cnt);
            pulse_start(pay, cnt, 1'b0);
        end
        stream_frames = stream_frames + (stream ? frames : 0);
        while (busy) begin
            @(negedge clk);
        end
        assert ((exp_q.size() == 0) && (rx_bits == 0))
            else stop_with_fail($sformatf("error at %0t: %0d bytes and %0d bits still missing",
                                          $time, exp_q.size(), rx_bits));
        assert (cs_falls == 1)
            else stop_with_fail($sformatf("error at %0t: cs fell %0d times in one group",
                                          $time, cs_falls));
    endtask

    initial begin
        rst           = 1'b1;
        start         = 1'b0;
        cmd           = CMD_SINGLE;
        payload       = '0;
        byte_cnt      = '0;
        div           = MIN_DIV;
        pol           = 1'b0;
        pha           = 1'b0;
        stream_frames = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (spi_cs && !busy && !almost && (spi_sck == pol))
            else stop_with_fail($sformatf("error at %0t: outputs not idle after reset", $time));
        for (int g = 0; g < NUM_GROUPS; g++) begin
            run_group();
        end
        assert (almost_cnt == stream_frames)
            else stop_with_fail($sformatf("error at %0t: %0d almost pulses for %0d frames",
                                          $time, almost_cnt, stream_frames));
        $display("Result: PASSED");
        $finish;
    end

    // bounds the run in case the DUT stalls
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_fail($sformatf("timeout: the tests did not finish within %0d cycles",
                                 WATCHDOG_CYCLES));
    end

endmodule

/* tb.f */
logic/spi_wr_pkg.sv
logic/spi_shift_if.sv
logic/spi_sck_gen.sv
logic/spi_byte_shifter.sv
logic/spi_frame_ctrl.sv
logic/spi_wr_top.sv
dv/spi_wr_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI write master testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module spi_wr_tb -o spi_wr_sim -f tb.f

./obj_dir/spi_wr_sim 2>&1 | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
else
    echo "simulation did not report a pass, see sim.log"
    exit 1
fi
